// ==== src/gat_pkg.sv ====
/*
 * graph-attention coefficient subsystem, shared definitions
 * sizes, word layout and fixed-point scaling used by every block
 */

package gat_pkg;

  // ==================================================================
  // feature and weight geometry
  // ==================================================================
  // power of two only, the adder tree is a full binary tree
  localparam int NUM_FEATURE_OUT = 8;
  localparam int A_SIZE          = 2 * NUM_FEATURE_OUT;

  localparam int DATA_WIDTH      = 8;
  localparam int WH_DATA_WIDTH   = 12;

  // features packed from the top down, source flag in bit 0
  localparam int WH_WORD_WIDTH   = NUM_FEATURE_OUT * WH_DATA_WIDTH + 1;

  // ==================================================================
  // arithmetic
  // ==================================================================
  localparam int PROD_WIDTH      = 20;
  localparam int DOT_WIDTH       = 24;

  // multiply stage, then one adder stage per tree level
  localparam int NUM_STAGES      = 1 + $clog2(NUM_FEATURE_OUT);

  // scales the sum down to the coefficient range
  localparam int COEF_SHIFT      = 16;

  // ==================================================================
  // coefficient FIFO
  // ==================================================================
  localparam int COEF_FIFO_DEPTH = 16;
  localparam int COEF_PTR_WIDTH  = $clog2(COEF_FIFO_DEPTH);
  localparam int COEF_CNT_WIDTH  = $clog2(COEF_FIFO_DEPTH + 1);

endpackage

// ==== src/wh_bus_if.sv ====
/*
 * decoded WH word bus, decode to execute
 * carries the unpacked features, the source flag and both weight halves
 */

`timescale 1ns/1ps

interface wh_bus_if;

  // one cycle per word
  logic                                                        vld;
  logic                                                        src_flag;
  logic [gat_pkg::NUM_FEATURE_OUT-1:0][gat_pkg::WH_DATA_WIDTH-1:0] wh;

  // weight halves, steady between reloads
  logic [gat_pkg::NUM_FEATURE_OUT-1:0][gat_pkg::DATA_WIDTH-1:0] a_src;
  logic [gat_pkg::NUM_FEATURE_OUT-1:0][gat_pkg::DATA_WIDTH-1:0] a_nbr;

  modport src (output vld, output src_flag, output wh, output a_src, output a_nbr);
  modport snk (input vld, input src_flag, input wh, input a_src, input a_nbr);

endinterface

// ==== src/dot_bus_if.sv ====
/*
 * dot product bus, execute to result
 * source and neighbor dot products of one word plus its flag
 */

`timescale 1ns/1ps

interface dot_bus_if;

  logic                                 vld;
  logic                                 src_flag;
  logic signed [gat_pkg::DOT_WIDTH-1:0] src_dot;
  logic signed [gat_pkg::DOT_WIDTH-1:0] nbr_dot;

  modport src (output vld, output src_flag, output src_dot, output nbr_dot);
  modport snk (input vld, input src_flag, input src_dot, input nbr_dot);

endinterface

// ==== src/wh_decode.sv ====
/*
 * WH decode stage
 * holds the attention weight vector and splits it into source and
 * neighbor halves, registers each WH word and unpacks its features
 */

`timescale 1ns/1ps

module wh_decode (
  input  logic                                                clk,
  input  logic                                                rst_n,
  input  logic                                                a_vld_i,
  input  logic [gat_pkg::A_SIZE-1:0][gat_pkg::DATA_WIDTH-1:0] a_i,
  input  logic                                                wh_vld_i,
  input  logic [gat_pkg::WH_WORD_WIDTH-1:0]                   wh_data_i,
  wh_bus_if.src                                               wh_o
);

  logic [gat_pkg::A_SIZE-1:0][gat_pkg::DATA_WIDTH-1:0] a_q;
  logic [gat_pkg::WH_WORD_WIDTH-1:0]                   wh_q;
  logic                                                vld_q;

  // ==================================================================
  // weight vector
  // ==================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_q <= '0;
    end else if (a_vld_i) begin
      a_q <= a_i;
    end
  end

  // ==================================================================
  // WH word register
  // ==================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= wh_vld_i;
    end
  end

  always_ff @(posedge clk) begin
    if (wh_vld_i) begin
      wh_q <= wh_data_i;
    end
  end

  // feature i comes from the top, weight entry i pairs with it
  for (genvar i = 0; i < gat_pkg::NUM_FEATURE_OUT; i++) begin : g_unpack
    assign wh_o.wh[i] =
      wh_q[gat_pkg::WH_WORD_WIDTH-1-i*gat_pkg::WH_DATA_WIDTH -: gat_pkg::WH_DATA_WIDTH];
    assign wh_o.a_src[i] = a_q[i];
    assign wh_o.a_nbr[i] = a_q[i+gat_pkg::NUM_FEATURE_OUT];
  end

  assign wh_o.src_flag = wh_q[0];
  assign wh_o.vld      = vld_q;

  // weights may only change between words
  a_wh_exclusive : assert property (@(posedge clk) disable iff (!rst_n)
    !(a_vld_i && wh_vld_i));

endmodule

// ==== src/dot_tree.sv ====
/*
 * dot product pipeline
 * one multiply stage followed by a registered binary adder tree,
 * source and neighbor lanes side by side, one word per cycle
 */

`timescale 1ns/1ps

module dot_tree (
  input  logic  clk,
  input  logic  rst_n,
  wh_bus_if.snk wh_i,
  dot_bus_if.src dot_o
);

  // products, combinational ahead of the leaf registers
  logic signed [gat_pkg::PROD_WIDTH-1:0] src_prod [gat_pkg::NUM_FEATURE_OUT];
  logic signed [gat_pkg::PROD_WIDTH-1:0] nbr_prod [gat_pkg::NUM_FEATURE_OUT];

  // tree in heap order: node 0 is the root, the last
  // NUM_FEATURE_OUT nodes are the registered products
  logic signed [gat_pkg::DOT_WIDTH-1:0] src_node_q [2*gat_pkg::NUM_FEATURE_OUT-1];
  logic signed [gat_pkg::DOT_WIDTH-1:0] nbr_node_q [2*gat_pkg::NUM_FEATURE_OUT-1];

  // valid and flag ride along with the data
  logic [gat_pkg::NUM_STAGES-1:0] vld_sr;
  logic [gat_pkg::NUM_STAGES-1:0] flag_sr;

  // ==================================================================
  // multiply stage
  // ==================================================================
  for (genvar i = 0; i < gat_pkg::NUM_FEATURE_OUT; i++) begin : g_mult
    assign src_prod[i] = $signed(wh_i.a_src[i]) * $signed(wh_i.wh[i]);
    assign nbr_prod[i] = $signed(wh_i.a_nbr[i]) * $signed(wh_i.wh[i]);
  end

  // ==================================================================
  // leaves and adder levels
  // ==================================================================
  always_ff @(posedge clk) begin
    for (int i = 0; i < gat_pkg::NUM_FEATURE_OUT; i++) begin
      // sign extended into the wider node
      src_node_q[gat_pkg::NUM_FEATURE_OUT-1+i] <= src_prod[i];
      nbr_node_q[gat_pkg::NUM_FEATURE_OUT-1+i] <= nbr_prod[i];
    end
    // every level advances each cycle, so words stay in lockstep
    for (int j = 0; j < gat_pkg::NUM_FEATURE_OUT - 1; j++) begin
      src_node_q[j] <= src_node_q[2*j+1] + src_node_q[2*j+2];
      nbr_node_q[j] <= nbr_node_q[2*j+1] + nbr_node_q[2*j+2];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_sr  <= '0;
      flag_sr <= '0;
    end else begin
      vld_sr  <= {vld_sr[gat_pkg::NUM_STAGES-2:0], wh_i.vld};
      flag_sr <= {flag_sr[gat_pkg::NUM_STAGES-2:0], wh_i.src_flag};
    end
  end

  assign dot_o.vld      = vld_sr[gat_pkg::NUM_STAGES-1];
  assign dot_o.src_flag = flag_sr[gat_pkg::NUM_STAGES-1];
  assign dot_o.src_dot  = src_node_q[0];
  assign dot_o.nbr_dot  = nbr_node_q[0];

  // fixed latency through the tree
  a_fixed_latency : assert property (@(posedge clk) disable iff (!rst_n)
    wh_i.vld |-> ##(gat_pkg::NUM_STAGES) dot_o.vld);

endmodule

// ==== src/coef_result.sv ====
/*
 * coefficient result stage
 * keeps the current source dot product, adds the neighbor term,
 * scales, truncates and applies ReLU before the FIFO write
 */

`timescale 1ns/1ps

module coef_result (
  input  logic                            clk,
  input  logic                            rst_n,
  dot_bus_if.snk                          dot_i,
  output logic                            coef_wr_o,
  output logic [gat_pkg::DATA_WIDTH-1:0]  coef_o,
  input  logic                            fifo_full_i
);

  logic signed [gat_pkg::DOT_WIDTH-1:0] src_dot_q;
  logic signed [gat_pkg::DOT_WIDTH-1:0] src_term;
  logic signed [gat_pkg::DOT_WIDTH-1:0] coef_sum;
  logic signed [gat_pkg::DOT_WIDTH-1:0] coef_shifted;
  logic        [gat_pkg::DATA_WIDTH-1:0] coef_trunc;
  logic        [gat_pkg::DATA_WIDTH-1:0] coef_q;
  logic                                  vld_q;

  // ==================================================================
  // coefficient arithmetic
  // ==================================================================
  // a flagged word uses its own source term right away
  assign src_term     = dot_i.src_flag ? dot_i.src_dot : src_dot_q;
  assign coef_sum     = src_term + dot_i.nbr_dot;
  assign coef_shifted = coef_sum >>> gat_pkg::COEF_SHIFT;
  assign coef_trunc   = coef_shifted[gat_pkg::DATA_WIDTH-1:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      src_dot_q <= '0;
      vld_q     <= 1'b0;
    end else begin
      vld_q <= dot_i.vld;
      if (dot_i.vld && dot_i.src_flag) begin
        src_dot_q <= dot_i.src_dot;
      end
    end
  end

  // ReLU on the truncated value
  always_ff @(posedge clk) begin
    if (dot_i.vld) begin
      coef_q <= coef_trunc[gat_pkg::DATA_WIDTH-1] ? '0 : coef_trunc;
    end
  end

  // ==================================================================
  // FIFO write
  // ==================================================================
  assign coef_o    = coef_q;
  // lost when the FIFO is full, nothing stalls upstream
  assign coef_wr_o = vld_q && !fifo_full_i;

  // written coefficients are non-negative and meet a FIFO with room
  a_write_valid : assert property (@(posedge clk) disable iff (!rst_n)
    coef_wr_o |-> (!fifo_full_i && !coef_o[gat_pkg::DATA_WIDTH-1]));

endmodule

// ==== src/coef_fifo.sv ====
/*
 * coefficient FIFO
 * show-ahead circular buffer, writes are dropped while full and
 * reads are ignored while empty
 */

`timescale 1ns/1ps

module coef_fifo (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           wr_i,
  input  logic [gat_pkg::DATA_WIDTH-1:0] din_i,
  input  logic                           rd_i,
  output logic [gat_pkg::DATA_WIDTH-1:0] dout_o,
  output logic                           empty_o,
  output logic                           full_o
);

  logic [gat_pkg::DATA_WIDTH-1:0]     mem [gat_pkg::COEF_FIFO_DEPTH];
  logic [gat_pkg::COEF_PTR_WIDTH-1:0] wr_ptr;
  logic [gat_pkg::COEF_PTR_WIDTH-1:0] rd_ptr;
  logic [gat_pkg::COEF_CNT_WIDTH-1:0] count;
  logic                               push;
  logic                               pop;

  assign push = wr_i && !full_o;
  assign pop  = rd_i && !empty_o;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= din_i;
    end
  end

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // oldest entry always on the output
  assign dout_o  = mem[rd_ptr];
  assign empty_o = (count == '0);
  assign full_o  = (count == gat_pkg::COEF_FIFO_DEPTH);

  a_no_pop_empty : assert property (@(posedge clk) disable iff (!rst_n)
    (rd_i && empty_o) |=> (rd_ptr == $past(rd_ptr)));

  // the result stage holds its write off while full
  a_no_push_full : assert property (@(posedge clk) disable iff (!rst_n)
    wr_i |-> !full_o);

endmodule

// ==== src/gat_coef_top.sv ====
/*
 * graph-attention coefficient top level
 * decode, dot product pipeline, coefficient result and output FIFO
 */

`timescale 1ns/1ps

module gat_coef_top (
  input  logic                                                clk,
  input  logic                                                rst_n,
  input  logic                                                a_vld_i,
  input  logic [gat_pkg::A_SIZE-1:0][gat_pkg::DATA_WIDTH-1:0] a_i,
  input  logic                                                wh_vld_i,
  input  logic [gat_pkg::WH_WORD_WIDTH-1:0]                   wh_data_i,
  input  logic                                                coef_rd_i,
  output logic [gat_pkg::DATA_WIDTH-1:0]                      coef_o,
  output logic                                                coef_empty_o,
  output logic                                                coef_full_o
);

  logic                           coef_wr;
  logic [gat_pkg::DATA_WIDTH-1:0] coef_din;

  wh_bus_if  wh_bus ();
  dot_bus_if dot_bus ();

  // ==================================================================
  // pipeline
  // ==================================================================
  wh_decode u_wh_decode (
    .clk       (clk),
    .rst_n     (rst_n),
    .a_vld_i   (a_vld_i),
    .a_i       (a_i),
    .wh_vld_i  (wh_vld_i),
    .wh_data_i (wh_data_i),
    .wh_o      (wh_bus.src)
  );

  dot_tree u_dot_tree (
    .clk   (clk),
    .rst_n (rst_n),
    .wh_i  (wh_bus.snk),
    .dot_o (dot_bus.src)
  );

  coef_result u_coef_result (
    .clk         (clk),
    .rst_n       (rst_n),
    .dot_i       (dot_bus.snk),
    .coef_wr_o   (coef_wr),
    .coef_o      (coef_din),
    .fifo_full_i (coef_full_o)
  );

  // ==================================================================
  // output buffer
  // ==================================================================
  coef_fifo u_coef_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_i    (coef_wr),
    .din_i   (coef_din),
    .rd_i    (coef_rd_i),
    .dout_o  (coef_o),
    .empty_o (coef_empty_o),
    .full_o  (coef_full_o)
  );

endmodule

// ==== verification/gat_coef_tb.sv ====
/*
 * graph-attention coefficient testbench
 * drives weights and WH words into the top level, predicts every
 * coefficient with a reference model and checks the FIFO output
 */

`timescale 1ns/1ps

module gat_coef_tb;

  localparam int NFO        = gat_pkg::NUM_FEATURE_OUT;
  localparam int FW         = gat_pkg::WH_DATA_WIDTH;
  localparam int WW         = gat_pkg::WH_WORD_WIDTH;
  localparam int DEPTH      = gat_pkg::COEF_FIFO_DEPTH;
  localparam int MAX_CYCLES = 2000;

  typedef logic [gat_pkg::A_SIZE-1:0][gat_pkg::DATA_WIDTH-1:0] weight_t;
  typedef logic [WW-1:0] word_t;

  logic                           clk;
  logic                           rst_n;
  logic                           a_vld_i;
  weight_t                        a_i;
  logic                           wh_vld_i;
  word_t                          wh_data_i;
  logic                           coef_rd_i;
  logic [gat_pkg::DATA_WIDTH-1:0] coef_o;
  logic                           coef_empty_o;
  logic                           coef_full_o;

  // reference model state
  weight_t                        cur_w;
  int                             model_src;
  logic [gat_pkg::DATA_WIDTH-1:0] exp_q[$];

  int seed;
  int errors;
  int cycles;
  int tests_run;
  int tests_failed;

  gat_coef_top UUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .a_vld_i      (a_vld_i),
    .a_i          (a_i),
    .wh_vld_i     (wh_vld_i),
    .wh_data_i    (wh_data_i),
    .coef_rd_i    (coef_rd_i),
    .coef_o       (coef_o),
    .coef_empty_o (coef_empty_o),
    .coef_full_o  (coef_full_o)
  );

  always #5 clk = ~clk;

  // ====================================================================
  // reference model
  // ====================================================================
  // one half of the weight vector against the word's features
  function automatic int dot_half(input weight_t w, input word_t word, input bit nbr);
    int acc;
    acc = 0;
    for (int i = 0; i < NFO; i++) begin
      acc += $signed(w[i + (nbr ? NFO : 0)]) * $signed(word[WW-1-i*FW -: FW]);
    end
    return acc;
  endfunction

  function automatic logic [7:0] ref_coef(input weight_t w, input word_t word,
                                          input int src_dot);
    int         src_term;
    int         sum;
    int         shifted;
    logic [7:0] trunc;
    src_term = word[0] ? dot_half(w, word, 1'b0) : src_dot;
    sum      = src_term + dot_half(w, word, 1'b1);
    shifted  = sum >>> gat_pkg::COEF_SHIFT;
    trunc    = shifted[7:0];
    // ReLU on the 8-bit value
    return trunc[7] ? 8'd0 : trunc;
  endfunction

  function automatic word_t random_word(input bit flag);
    word_t word;
    int    r;
    word = '0;
    for (int i = 0; i < NFO; i++) begin
      r = $random(seed);
      word[WW-1-i*FW -: FW] = r[FW-1:0];
    end
    word[0] = flag;
    return word;
  endfunction

  function automatic word_t fill_word(input int feat, input bit flag);
    word_t word;
    word = '0;
    for (int i = 0; i < NFO; i++) begin
      word[WW-1-i*FW -: FW] = feat[FW-1:0];
    end
    word[0] = flag;
    return word;
  endfunction

  // ====================================================================
  // stimulus tasks
  // ====================================================================
  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      wh_vld_i <= 1'b0;
      a_vld_i  <= 1'b0;
    end
  endtask

  // waits for the pipeline to empty before the weights change
  task automatic load_weights(input weight_t w);
    idle_cycles(gat_pkg::NUM_STAGES + 3);
    cur_w = w;
    @(posedge clk);
    a_vld_i  <= 1'b1;
    a_i      <= w;
    wh_vld_i <= 1'b0;
    idle_cycles(1);
  endtask

  task automatic random_weights();
    weight_t w;
    int      r;
    for (int i = 0; i < gat_pkg::A_SIZE; i++) begin
      r    = $random(seed);
      w[i] = r[7:0];
    end
    load_weights(w);
  endtask

  // keep is cleared for words that will meet a full FIFO
  task automatic send_word(input word_t word, input bit keep);
    logic [7:0] expected;
    expected = ref_coef(cur_w, word, model_src);
    if (word[0]) begin
      model_src = dot_half(cur_w, word, 1'b0);
    end
    if (keep) begin
      exp_q.push_back(expected);
    end
    @(posedge clk);
    a_vld_i   <= 1'b0;
    wh_vld_i  <= 1'b1;
    wh_data_i <= word;
  endtask

  task automatic drain_results();
    idle_cycles(1);
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
    if (!coef_empty_o) begin
      $display("FIFO still holds data after all expected coefficients were read");
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: FAIL (%0d errors)", name, errors - err_before);
    end
  endtask

  // ====================================================================
  // checker and timeout
  // ====================================================================
  // a pop happens on each edge where a read meets a non-empty FIFO
  always @(posedge clk) begin
    if (rst_n && coef_rd_i && !coef_empty_o) begin
      if (exp_q.size() == 0) begin
        $display("unexpected coefficient %0d read from the FIFO at %0t", coef_o, $time);
        errors++;
      end else if (coef_o !== exp_q[0]) begin
        $display("mismatch at %0t: coefficient %0d, expected %0d", $time, coef_o, exp_q[0]);
        errors++;
        void'(exp_q.pop_front());
      end else begin
        void'(exp_q.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run stopped after %0d cycles with %0d results outstanding",
               cycles, exp_q.size());
      $display("Done: errors found");
      $finish;
    end
  end

  // ====================================================================
  // test sequence
  // ====================================================================
  initial begin
    int err_before;
    weight_t w;
    clk       = 1'b0;
    rst_n     = 1'b0;
    a_vld_i   = 1'b0;
    a_i       = '0;
    wh_vld_i  = 1'b0;
    wh_data_i = '0;
    coef_rd_i = 1'b0;
    cur_w     = '0;
    model_src = 0;
    seed      = 32'ha1dd3cb1;
    errors    = 0;
    cycles    = 0;
    tests_run    = 0;
    tests_failed = 0;

    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    err_before = errors;
    if (!coef_empty_o || coef_full_o) begin
      $display("FIFO flags wrong after reset: empty %b full %b", coef_empty_o, coef_full_o);
      errors++;
    end
    end_test("reset state", err_before);

    // 1: one source word, then a long run of neighbors
    err_before = errors;
    coef_rd_i <= 1'b1;
    random_weights();
    send_word(random_word(1'b1), 1'b1);
    for (int i = 0; i < 20; i++) begin
      send_word(random_word(1'b0), 1'b1);
    end
    drain_results();
    end_test("basic coefficients", err_before);

    // 2: groups separated by idle gaps
    err_before = errors;
    for (int g = 0; g < 4; g++) begin
      send_word(random_word(1'b1), 1'b1);
      for (int i = 0; i < 3 + g; i++) begin
        send_word(random_word(1'b0), 1'b1);
      end
      idle_cycles(2 + g);
    end
    drain_results();
    end_test("source replacement", err_before);

    // 3: positive, exactly zero and negative sums
    err_before = errors;
    w = '0;
    for (int i = 0; i < gat_pkg::A_SIZE; i++) begin
      w[i] = 8'sd127;
    end
    load_weights(w);
    send_word(fill_word(2047, 1'b1), 1'b1);
    send_word(fill_word(-2047, 1'b0), 1'b1);
    send_word(fill_word(-2048, 1'b0), 1'b1);
    send_word(fill_word(0, 1'b0), 1'b1);
    send_word(fill_word(1000, 1'b1), 1'b1);
    send_word(fill_word(-2048, 1'b1), 1'b1);
    send_word(fill_word(2047, 1'b0), 1'b1);
    send_word(fill_word(-1, 1'b0), 1'b1);
    drain_results();
    end_test("relu and shift", err_before);

    // 4: fresh weights ahead of each group
    err_before = errors;
    for (int g = 0; g < 3; g++) begin
      random_weights();
      send_word(random_word(1'b1), 1'b1);
      for (int i = 0; i < 5; i++) begin
        send_word(random_word(1'b0), 1'b1);
      end
    end
    drain_results();
    end_test("weight reload", err_before);

    // 5: overfill without reading, words past the depth are lost
    err_before = errors;
    @(posedge clk);
    coef_rd_i <= 1'b0;
    send_word(random_word(1'b1), 1'b1);
    for (int i = 1; i < 20; i++) begin
      send_word(random_word(1'b0), i < DEPTH);
    end
    idle_cycles(gat_pkg::NUM_STAGES + 4);
    if (!coef_full_o) begin
      $display("coef_full_o did not rise with %0d entries held", DEPTH);
      errors++;
    end
    @(posedge clk);
    coef_rd_i <= 1'b1;
    drain_results();
    if (coef_full_o) begin
      $display("coef_full_o still high after the FIFO was emptied");
      errors++;
    end
    end_test("fifo full and empty", err_before);

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== gat_coef.f ====
src/gat_pkg.sv
src/wh_bus_if.sv
src/dot_bus_if.sv
src/wh_decode.sv
src/dot_tree.sv
src/coef_result.sv
src/coef_fifo.sv
src/gat_coef_top.sv
verification/gat_coef_tb.sv

// ==== Makefile ====
# Verilator build and run for the graph-attention coefficient subsystem

VERILATOR ?= verilator
TOP       ?= gat_coef_tb
FILELIST  ?= gat_coef.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Done: errors found
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi; \
	echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
